// ==== lsab.f ====
+incdir+rtl
rtl/lsab_pkg.sv
rtl/lsab_queue_ctrl.sv
rtl/lsab_sram.sv
rtl/lsab_out_steer.sv
rtl/lsab_top.sv
tests/lsab_tb.sv

// ==== rtl/lsab_macros.svh ====
`ifndef LSAB_MACROS_SVH
`define LSAB_MACROS_SVH

// lane count and lane select width
`define LSAB_LANES      4
`define LSAB_SEL_BITS   2

// payload word
`define LSAB_WORD_BITS  32

// per-lane pointer and length, one 64-word region per lane
`define LSAB_PTR_BITS   6

// shared RAM address is {lane, pointer}
`define LSAB_ADDR_BITS  8

// occupancy limits
`define LSAB_CAPACITY   63
`define LSAB_NEAR_FULL  55

`endif

// ==== rtl/lsab_out_steer.sv ====
`default_nettype none

`include "lsab_macros.svh"

module lsab_out_steer
  import lsab_pkg::*;
(
  input  wire logic      CLK,
  input  wire logic      RST,
  input  wire logic      re,
  input  wire lane_sel_t rlane,
  input  wire word_t     rdata,
  output lane_words_t    out_data
);

  logic      re_q;     // RAM word valid this cycle
  lane_sel_t rlane_q;  // lane it belongs to

  always_ff @(posedge CLK) begin
    if (!RST)
      re_q <= 1'b0;
    else
      re_q <= re;
  end

  always_ff @(posedge CLK) begin
    rlane_q <= rlane;
  end

  // only the lane just read updates, the rest hold
  always_ff @(posedge CLK) begin
    if (!RST) begin
      out_data <= '0;
    end else if (re_q) begin
      out_data[rlane_q] <= rdata;
    end
  end

  // no RAM read accepted straight out of reset
  a_no_read_in_reset: assert property (
    @(posedge CLK)
    !RST |=> !re
  );

endmodule

`default_nettype wire

// ==== rtl/lsab_pkg.sv ====
`default_nettype none

`include "lsab_macros.svh"

package lsab_pkg;

  // lane number
  typedef logic [`LSAB_SEL_BITS-1:0] lane_sel_t;

  // data word
  typedef logic [`LSAB_WORD_BITS-1:0] word_t;

  // per-lane pointer or length
  typedef logic [`LSAB_PTR_BITS-1:0] lane_ptr_t;

  // RAM address, lane on top
  typedef logic [`LSAB_ADDR_BITS-1:0] ram_addr_t;

  // one bit per lane
  typedef logic [`LSAB_LANES-1:0] lane_mask_t;

  // one output word per lane
  typedef word_t [`LSAB_LANES-1:0] lane_words_t;

  // one read and one write into the shared RAM each cycle
  typedef struct packed {
    logic      re;     // accepted read
    ram_addr_t raddr;
    lane_sel_t rlane;  // lane that gets the word
    logic      we;     // accepted write
    ram_addr_t waddr;
    word_t     wdata;
  } ram_req_t;

endpackage

`default_nettype wire

// ==== rtl/lsab_queue_ctrl.sv ====
`default_nettype none

`include "lsab_macros.svh"

module lsab_queue_ctrl
  import lsab_pkg::*;
(
  input  wire logic       CLK,
  input  wire logic       RST,
  input  wire logic       write,
  input  wire lane_sel_t  write_sel,
  input  wire word_t      write_data,
  input  wire lane_mask_t read,
  input  wire lane_sel_t  read_sel,
  output ram_req_t        ram_req,
  output lane_mask_t      near_full
);

  localparam lane_ptr_t CAP     = lane_ptr_t'(`LSAB_CAPACITY);
  localparam lane_ptr_t NF_LVL  = lane_ptr_t'(`LSAB_NEAR_FULL);
  localparam lane_ptr_t ONE     = lane_ptr_t'(1);

  lane_mask_t do_read;   // accepted reads
  lane_mask_t do_write;  // accepted writes
  lane_ptr_t  rd_ptr [`LSAB_LANES];
  lane_ptr_t  wr_ptr [`LSAB_LANES];

  genvar i;
  generate
    for (i = 0; i < `LSAB_LANES; i++) begin : g_lane
      lane_ptr_t len_q;
      lane_ptr_t len_d;
      lane_ptr_t rd_ptr_q;
      lane_ptr_t wr_ptr_q;
      logic      empty_q;
      logic      empty_d;
      logic      full_q;
      logic      full_d;
      logic      nf_q;
      logic      nf_d;
      logic      rd_req;
      logic      wr_req;
      logic      inc;
      logic      dec;

      assign rd_req = read[i] && (read_sel == lane_sel_t'(i));
      assign wr_req = write && (write_sel == lane_sel_t'(i));

      // full lane drops writes, empty lane drops reads
      assign do_read[i]  = rd_req && !empty_q;
      assign do_write[i] = wr_req && !full_q;

      // read plus write on the same lane leaves the length alone
      assign inc = do_write[i] && !do_read[i];
      assign dec = do_read[i] && !do_write[i];

      // flags only move on threshold crossings
      always_comb begin
        len_d   = len_q;
        empty_d = empty_q;
        full_d  = full_q;
        nf_d    = nf_q;
        if (inc) begin
          len_d = len_q + ONE;
          if (len_q == '0)
            empty_d = 1'b0;
          if (len_q == CAP - ONE)
            full_d = 1'b1;    // entering 63
          if (len_q == NF_LVL - ONE)
            nf_d = 1'b1;      // 54 -> 55
        end else if (dec) begin
          len_d = len_q - ONE;
          if (len_q == ONE)
            empty_d = 1'b1;   // leaving 1
          if (len_q == CAP)
            full_d = 1'b0;
          if (len_q == NF_LVL)
            nf_d = 1'b0;      // 55 -> 54
        end
      end

      always_ff @(posedge CLK) begin
        if (!RST) begin
          len_q    <= '0;
          empty_q  <= 1'b1;
          full_q   <= 1'b0;
          nf_q     <= 1'b0;
          rd_ptr_q <= '0;
          wr_ptr_q <= '0;
        end else begin
          len_q   <= len_d;
          empty_q <= empty_d;
          full_q  <= full_d;
          nf_q    <= nf_d;
          if (do_read[i])
            rd_ptr_q <= rd_ptr_q + ONE;  // wraps inside the lane region
          if (do_write[i])
            wr_ptr_q <= wr_ptr_q + ONE;
        end
      end

      assign rd_ptr[i]    = rd_ptr_q;
      assign wr_ptr[i]    = wr_ptr_q;
      assign near_full[i] = nf_q;

      // no growth once at capacity
      a_len_cap: assert property (
        @(posedge CLK) disable iff (!RST)
        inc |-> (len_q < CAP)
      );

      a_full_nf: assert property (
        @(posedge CLK) disable iff (!RST)
        full_q |-> nf_q
      );

      a_empty_len: assert property (
        @(posedge CLK) disable iff (!RST)
        empty_q |-> (len_q == '0)
      );
    end
  endgenerate

  // one RAM access per direction, addressed by the selected lane
  always_comb begin
    ram_req.re    = do_read[read_sel];
    ram_req.raddr = {read_sel, rd_ptr[read_sel]};
    ram_req.rlane = read_sel;
    ram_req.we    = do_write[write_sel];
    ram_req.waddr = {write_sel, wr_ptr[write_sel]};
    ram_req.wdata = write_data;
  end

endmodule

`default_nettype wire

// ==== rtl/lsab_sram.sv ====
`default_nettype none

`include "lsab_macros.svh"

module lsab_sram
  import lsab_pkg::*;
(
  input  wire logic      CLK,
  input  wire logic      re,
  input  wire ram_addr_t raddr,
  input  wire logic      we,
  input  wire ram_addr_t waddr,
  input  wire word_t     wdata,
  output word_t          rdata
);

  localparam int unsigned DEPTH = 2 ** `LSAB_ADDR_BITS;

  // all four lane regions side by side
  word_t mem [DEPTH];

  always_ff @(posedge CLK) begin
    if (we)
      mem[waddr] <= wdata;
  end

  // registered read, holds between reads
  always_ff @(posedge CLK) begin
    if (re)
      rdata <= mem[raddr];
  end

  // a lane holds at most 63 words, so a live read never hits the write slot
  a_no_collide: assert property (
    @(posedge CLK)
    (re && we) |-> (raddr != waddr)
  );

endmodule

`default_nettype wire

// ==== rtl/lsab_top.sv ====
`default_nettype none

module lsab_top
  import lsab_pkg::*;
(
  input  wire logic        CLK,
  input  wire logic        RST,
  input  wire logic        write,
  input  wire lane_sel_t   write_sel,
  input  wire word_t       write_data,
  input  wire lane_mask_t  read,
  input  wire lane_sel_t   read_sel,
  output wire lane_words_t out_data,
  output wire lane_mask_t  near_full
);

  wire ram_req_t ram_req;  // this cycle's RAM access
  wire word_t    rdata;    // registered RAM output

  lsab_queue_ctrl u_queue_ctrl (
    .CLK        (CLK),
    .RST        (RST),
    .write      (write),
    .write_sel  (write_sel),
    .write_data (write_data),
    .read       (read),
    .read_sel   (read_sel),
    .ram_req    (ram_req),
    .near_full  (near_full)
  );

  lsab_sram u_sram (
    .CLK   (CLK),
    .re    (ram_req.re),
    .raddr (ram_req.raddr),
    .we    (ram_req.we),
    .waddr (ram_req.waddr),
    .wdata (ram_req.wdata),
    .rdata (rdata)
  );

  // lane tag rides along with the read enable
  lsab_out_steer u_out_steer (
    .CLK      (CLK),
    .RST      (RST),
    .re       (ram_req.re),
    .rlane    (ram_req.rlane),
    .rdata    (rdata),
    .out_data (out_data)
  );

endmodule

`default_nettype wire

// ==== tests/lsab_tb.sv ====
`default_nettype none

`include "lsab_macros.svh"

module lsab_tb
  import lsab_pkg::*;
();

  // predicted DUT outputs after one rising edge
  typedef struct packed {
    lane_words_t out;
    lane_mask_t  nf;
  } model_t;

  logic        CLK;
  logic        RST;
  logic        write;
  lane_sel_t   write_sel;
  word_t       write_data;
  lane_mask_t  read;
  lane_sel_t   read_sel;
  lane_words_t out_data;
  lane_mask_t  near_full;

  word_t       model_q [`LSAB_LANES][$];  // reference queues
  logic        pend_valid;                // word popped, lands next edge
  lane_sel_t   pend_lane;
  word_t       pend_word;
  model_t      exp;
  logic        model_live;
  logic        rst_released;
  word_t       saved;

  lsab_top DUT (
    .CLK        (CLK),
    .RST        (RST),
    .write      (write),
    .write_sel  (write_sel),
    .write_data (write_data),
    .read       (read),
    .read_sel   (read_sel),
    .out_data   (out_data),
    .near_full  (near_full)
  );

  always #4 CLK = ~CLK;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want)
      abort_run($sformatf("Fail at time %0t: %s is %h, expected %h", $time, name, got, want));
  endtask

  // one rising edge of the queue rules
  function automatic model_t step_model(input model_t prev, input logic wr,
                                        input lane_sel_t wsel, input word_t wdata,
                                        input lane_mask_t rd, input lane_sel_t rsel);
    model_t nxt;
    logic   rd_ok;
    logic   wr_ok;
    nxt = prev;
    if (pend_valid)
      nxt.out[pend_lane] = pend_word;  // read from the previous edge lands
    rd_ok = rd[rsel] && (model_q[rsel].size() > 0);
    wr_ok = wr && (model_q[wsel].size() < `LSAB_CAPACITY);
    pend_valid = rd_ok;
    pend_lane  = rsel;
    if (rd_ok)
      pend_word = model_q[rsel].pop_front();
    if (wr_ok)
      model_q[wsel].push_back(wdata);
    for (int l = 0; l < `LSAB_LANES; l++)
      nxt.nf[l] = (model_q[l].size() >= `LSAB_NEAR_FULL);
    return nxt;
  endfunction

  always @(posedge CLK) begin
    if (!RST) begin
      for (int l = 0; l < `LSAB_LANES; l++)
        model_q[l].delete();
      pend_valid = 1'b0;
      exp        = '0;
      model_live = 1'b1;
    end else begin
      exp          = step_model(exp, write, write_sel, write_data, read, read_sel);
      rst_released = 1'b1;
    end
  end

  // outputs are registered, so the falling edge sees them settled
  always @(negedge CLK) begin
    if (model_live) begin
      for (int l = 0; l < `LSAB_LANES; l++)
        check_value($sformatf("out_data[%0d]", l), out_data[l], exp.out[l]);
      check_value("near_full", 32'(near_full), 32'(exp.nf));
    end
  end

  task automatic drive_inputs(input logic wr, input lane_sel_t wsel, input word_t wdata,
                              input lane_mask_t rd, input lane_sel_t rsel);
    @(negedge CLK);
    write      = wr;
    write_sel  = wsel;
    write_data = wdata;
    read       = rd;
    read_sel   = rsel;
  endtask

  task automatic idle_cycle();
    drive_inputs(1'b0, '0, '0, '0, '0);
  endtask

  task automatic write_words(input int lane, input int count, input word_t base);
    for (int n = 0; n < count; n++)
      drive_inputs(1'b1, lane_sel_t'(lane), base + word_t'(n), '0, '0);
    idle_cycle();
  endtask

  task automatic drain_lane(input int lane);
    int guard;
    guard = 0;
    while (model_q[lane].size() > 0) begin
      drive_inputs(1'b0, '0, '0, lane_mask_t'(1 << lane), lane_sel_t'(lane));
      guard++;
      if (guard > 2 * `LSAB_CAPACITY)
        abort_run($sformatf("Timeout while draining lane %0d", lane));
    end
    idle_cycle();
    idle_cycle();  // last word reaches its output
  endtask

  initial begin
    int guard;
    CLK          = 1'b0;
    RST          = 1'b0;
    write        = 1'b0;
    write_sel    = '0;
    write_data   = '0;
    read         = '0;
    read_sel     = '0;
    model_live   = 1'b0;
    rst_released = 1'b0;
    pend_valid   = 1'b0;
    exp          = '0;
    void'($urandom(34));

    repeat (4) @(negedge CLK);
    RST = 1'b1;
    guard = 0;
    while (!rst_released) begin
      @(negedge CLK);
      guard++;
      if (guard > 10)
        abort_run("Timeout waiting for reset release");
    end

    // reads before any write leave outputs at zero
    for (int l = 0; l < `LSAB_LANES; l++)
      drive_inputs(1'b0, '0, '0, '1, lane_sel_t'(l));
    idle_cycle();
    idle_cycle();
    check_value("out_data after empty reads", 32'(out_data != '0), 32'd0);

    // random traffic on all lanes
    for (int n = 0; n < 400; n++)
      drive_inputs(($urandom % 10) < 6, lane_sel_t'($urandom), word_t'($urandom),
                   lane_mask_t'($urandom), lane_sel_t'($urandom));
    idle_cycle();
    for (int l = 0; l < `LSAB_LANES; l++)
      drain_lane(l);

    // near-full threshold on lane 1
    write_words(1, 54, 32'h1100_0000);
    check_value("near_full[1] at 54", 32'(near_full[1]), 32'd0);
    write_words(1, 1, 32'h1100_0036);
    check_value("near_full[1] at 55", 32'(near_full[1]), 32'd1);
    check_value("near_full other lanes", 32'(near_full & 4'b1101), 32'd0);
    drive_inputs(1'b0, '0, '0, 4'b0010, 2'd1);
    idle_cycle();
    check_value("near_full[1] back at 54", 32'(near_full[1]), 32'd0);
    drain_lane(1);

    // overflow on lane 2 keeps the first 63 words
    write_words(2, 70, 32'hC0DE_0000);
    check_value("near_full[2] when full", 32'(near_full[2]), 32'd1);
    drain_lane(2);
    check_value("out_data[2] last kept word", out_data[2], 32'hC0DE_003E);
    for (int n = 0; n < 5; n++)
      drive_inputs(1'b0, '0, '0, 4'b0100, 2'd2);
    idle_cycle();
    idle_cycle();
    check_value("out_data[2] after empty reads", out_data[2], 32'hC0DE_003E);

    // read_sel on lane 3 with its read bit low
    write_words(3, 3, 32'h3300_0000);
    saved = out_data[3];
    for (int n = 0; n < 4; n++)
      drive_inputs(1'b0, '0, '0, 4'b0111, 2'd3);
    idle_cycle();
    idle_cycle();
    check_value("out_data[3] with read bit low", out_data[3], saved);
    drain_lane(3);
    saved = out_data[3];
    for (int n = 0; n < 4; n++)
      drive_inputs(1'b0, '0, '0, '1, 2'd3);
    idle_cycle();
    idle_cycle();
    check_value("out_data[3] empty lane read", out_data[3], saved);

    // steady flow on lane 0 at constant occupancy
    write_words(0, 56, 32'h0A00_0000);
    for (int n = 0; n < 40; n++) begin
      drive_inputs(1'b1, 2'd0, 32'h0B00_0000 + word_t'(n), 4'b0001, 2'd0);
      check_value("near_full[0] steady", 32'(near_full[0]), 32'd1);
    end
    idle_cycle();
    drain_lane(0);

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire
